/* Makefile */
# Verilator build and run of the manycore link testbench

VERILATOR ?= verilator
TOP       ?= tb_manycore
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
manycore_link_pkg.sv
manycore_host_pkg.sv
manycore_link_fifo.sv
manycore_resp_timer.sv
manycore_link_tieoff.sv
manycore_tile.sv
manycore_io_ctrl.sv
manycore_top.sv
tb_manycore.sv

/* manycore_host_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host side definitions: how the Wishbone word address splits into a tile
// coordinate and a word index, and how long the host waits for a return.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package manycore_host_pkg;

  // wb address {x, word}
  localparam int WB_ADDR_W = 6;
  localparam int WB_WORD_W = 4;
  localparam int WB_X_W    = WB_ADDR_W - WB_WORD_W;

  localparam int RESP_TIMEOUT = 32;  // cycles
  localparam int TIMER_W      = 6;

endpackage

/* manycore_io_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bridge. Turns each Wishbone classic access into a load or store
// request on the forward link and ends the cycle with ack on the matching
// return, or with err when the response timer runs out.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module manycore_io_ctrl (
  input  logic                                   clk,
  input  logic                                   arst_n_i,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [manycore_host_pkg::WB_ADDR_W-1:0] wb_adr_i,
  input  logic [manycore_link_pkg::DATA_W-1:0]    wb_dat_i,
  output logic [manycore_link_pkg::DATA_W-1:0]    wb_dat_o,
  output logic                                   wb_ack_o,
  output logic                                   wb_err_o,
  output logic                                   fwd_v_o,
  output manycore_link_pkg::fwd_pkt_t             fwd_data_o,
  input  logic                                   fwd_ready_i,
  input  logic                                   ret_v_i,
  input  manycore_link_pkg::ret_pkt_t             ret_data_i,
  output logic                                   ret_ready_o,
  output logic                                   timer_start_o,
  output logic                                   timer_stop_o,
  input  logic                                   timer_expired_i
);

  typedef enum logic [2:0] {IDLE, SEND, WAIT, DONE, FAIL} state_e;

  state_e                               state_q;
  manycore_link_pkg::fwd_pkt_t          req_q;
  logic [manycore_link_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (wb_cyc_i && wb_stb_i) state_q <= SEND;  // stray returns dropped here
        SEND:    if (fwd_ready_i) state_q <= WAIT;
        WAIT: begin
          if (ret_v_i) state_q <= DONE;
          else if (timer_expired_i) state_q <= FAIL;
        end
        default: state_q <= IDLE;  // DONE and FAIL last one cycle
      endcase
    end
  end

  // request packet latched as the strobe is seen
  always_ff @(posedge clk) begin
    if (state_q == IDLE && wb_cyc_i && wb_stb_i) begin
      req_q <= '0;
      req_q[manycore_link_pkg::FWD_OP_BIT] <=
        wb_we_i ? manycore_link_pkg::OP_STORE : manycore_link_pkg::OP_LOAD;
      req_q[manycore_link_pkg::FWD_X_LSB +: manycore_link_pkg::X_CORD_W] <=
        wb_adr_i[manycore_host_pkg::WB_ADDR_W-1 -: manycore_host_pkg::WB_X_W];
      req_q[manycore_link_pkg::FWD_ADDR_LSB +: manycore_link_pkg::WORD_ADDR_W] <=
        wb_adr_i[manycore_host_pkg::WB_WORD_W-1:0];
      req_q[manycore_link_pkg::FWD_DATA_LSB +: manycore_link_pkg::DATA_W] <= wb_dat_i;
    end
    if (state_q == WAIT && ret_v_i) begin
      rdata_q <= ret_data_i[manycore_link_pkg::RET_DATA_LSB +: manycore_link_pkg::DATA_W];
    end
  end

  assign fwd_v_o     = (state_q == SEND);
  assign fwd_data_o  = req_q;
  assign ret_ready_o = 1'b1;

  assign timer_start_o = (state_q == SEND) & fwd_ready_i;
  assign timer_stop_o  = (state_q == WAIT) & ret_v_i;

  assign wb_ack_o = (state_q == DONE);
  assign wb_err_o = (state_q == FAIL);
  assign wb_dat_o = rdata_q;

endmodule

/* manycore_link_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry valid/ready buffer for link packets. The consumer pulls an item
// with yumi_i while v_o is high. Payload type is set per instance.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module manycore_link_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       enq;
  logic       deq;

  assign ready_o = (count_q != 2'd2);
  assign v_o     = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (enq) wr_ptr_q <= ~wr_ptr_q;
      if (deq) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, enq} - {1'b0, deq};  // both at once keeps count
    end
  end

  always_ff @(posedge clk) begin
    if (enq) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

/* manycore_link_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link-level definitions shared by the tiles, the tie-off and the host
// controller: coordinate, address and data widths, opcodes and the layout
// of request and return packets. Referenced by scoped name only.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package manycore_link_pkg;

  localparam int X_CORD_W    = 2;  // coordinates 0..3
  localparam int NUM_TILES   = 2;  // tiles sit at x 0 and 1
  localparam int WORD_ADDR_W = 4;  // 16 words per tile
  localparam int DATA_W      = 32;

  localparam logic OP_LOAD  = 1'b0;
  localparam logic OP_STORE = 1'b1;

  // request packet {op, x, word, data}
  localparam int FWD_DATA_LSB = 0;
  localparam int FWD_ADDR_LSB = FWD_DATA_LSB + DATA_W;
  localparam int FWD_X_LSB    = FWD_ADDR_LSB + WORD_ADDR_W;
  localparam int FWD_OP_BIT   = FWD_X_LSB + X_CORD_W;
  localparam int FWD_PKT_W    = FWD_OP_BIT + 1;  // 39

  // return packet {op echo, data}
  localparam int RET_DATA_LSB = 0;
  localparam int RET_OP_BIT   = RET_DATA_LSB + DATA_W;
  localparam int RET_PKT_W    = RET_OP_BIT + 1;  // 33

  typedef logic [FWD_PKT_W-1:0] fwd_pkt_t;
  typedef logic [RET_PKT_W-1:0] ret_pkt_t;

endpackage

/* manycore_link_tieoff.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// East edge of the row. Swallows any request that ran past the last tile
// and keeps a misroute flag up until reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module manycore_link_tieoff (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        fwd_v_i,
  input  manycore_link_pkg::fwd_pkt_t fwd_data_i,
  output logic                        fwd_ready_o,
  output logic                        misroute_o
);

  logic [manycore_link_pkg::X_CORD_W-1:0] dest_x;
  logic                                   misroute_q;

  assign fwd_ready_o = 1'b1;  // never stalls
  assign dest_x      = fwd_data_i[manycore_link_pkg::FWD_X_LSB +: manycore_link_pkg::X_CORD_W];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      misroute_q <= 1'b0;
    end else if (fwd_v_i && int'(dest_x) >= manycore_link_pkg::NUM_TILES) begin
      misroute_q <= 1'b1;  // sticky
    end
  end

  assign misroute_o = misroute_q;

endmodule

/* manycore_resp_timer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response watchdog for the host controller. Armed by start_i, disarmed by
// stop_i, pulses expired_o once RESP_TIMEOUT cycles pass without a stop.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module manycore_resp_timer (
  input  logic clk,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  logic [manycore_host_pkg::TIMER_W-1:0] cnt_q;
  logic                                  armed_q;
  logic                                  expired_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q     <= '0;
      armed_q   <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      expired_q <= 1'b0;
      if (start_i) begin
        cnt_q   <= '0;
        armed_q <= 1'b1;
      end else if (stop_i) begin
        armed_q <= 1'b0;
      end else if (armed_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == manycore_host_pkg::TIMER_W'(manycore_host_pkg::RESP_TIMEOUT - 1)) begin
          armed_q   <= 1'b0;
          expired_q <= 1'b1;  // one pulse
        end
      end
    end
  end

  assign expired_o = expired_q;

endmodule

/* manycore_tile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory tile of the row. Requests for my_x_p hit the 16-word data memory
// and answer on the return link; others are passed east. Returns from the
// east are merged westward behind the tile's own responses.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module manycore_tile #(
  parameter logic [manycore_link_pkg::X_CORD_W-1:0] my_x_p = '0
) (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        fwd_v_i,
  input  manycore_link_pkg::fwd_pkt_t fwd_data_i,
  output logic                        fwd_ready_o,
  output logic                        fwd_v_o,
  output manycore_link_pkg::fwd_pkt_t fwd_data_o,
  input  logic                        fwd_ready_i,
  input  logic                        ret_v_i,
  input  manycore_link_pkg::ret_pkt_t ret_data_i,
  output logic                        ret_ready_o,
  output logic                        ret_v_o,
  output manycore_link_pkg::ret_pkt_t ret_data_o,
  input  logic                        ret_ready_i
);

  manycore_link_pkg::fwd_pkt_t                fin_data;
  logic                                       fin_v;
  logic                                       fin_yumi;
  logic [manycore_link_pkg::X_CORD_W-1:0]     fin_x;
  logic [manycore_link_pkg::WORD_ADDR_W-1:0]  fin_addr;
  logic [manycore_link_pkg::DATA_W-1:0]       fin_wdata;
  logic                                       fin_op;
  logic                                       fin_mine;
  logic                                       consume;

  manycore_link_pkg::ret_pkt_t                resp_in;
  manycore_link_pkg::ret_pkt_t                resp_data;
  logic                                       resp_ready;
  logic                                       resp_v;
  logic                                       resp_yumi;

  manycore_link_pkg::ret_pkt_t                east_data;
  logic                                       east_v;
  logic                                       east_yumi;

  logic [manycore_link_pkg::DATA_W-1:0] mem_q [2**manycore_link_pkg::WORD_ADDR_W];

  manycore_link_fifo #(.payload_t(manycore_link_pkg::fwd_pkt_t)) fwd_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .v_i      (fwd_v_i),
    .data_i   (fwd_data_i),
    .ready_o  (fwd_ready_o),
    .v_o      (fin_v),
    .data_o   (fin_data),
    .yumi_i   (fin_yumi)
  );

  // request decode
  assign fin_op    = fin_data[manycore_link_pkg::FWD_OP_BIT];
  assign fin_x     = fin_data[manycore_link_pkg::FWD_X_LSB +: manycore_link_pkg::X_CORD_W];
  assign fin_addr  = fin_data[manycore_link_pkg::FWD_ADDR_LSB +: manycore_link_pkg::WORD_ADDR_W];
  assign fin_wdata = fin_data[manycore_link_pkg::FWD_DATA_LSB +: manycore_link_pkg::DATA_W];
  assign fin_mine  = (fin_x == my_x_p);

  assign consume  = fin_v & fin_mine & resp_ready;
  assign fin_yumi = consume | (fin_v & ~fin_mine & fwd_ready_i);

  // pass-through east
  assign fwd_v_o    = fin_v & ~fin_mine;
  assign fwd_data_o = fin_data;

  always_ff @(posedge clk) begin
    if (consume && fin_op == manycore_link_pkg::OP_STORE) mem_q[fin_addr] <= fin_wdata;
  end

  // store answers with the written word, load with the stored one
  always_comb begin
    resp_in = '0;
    resp_in[manycore_link_pkg::RET_OP_BIT] = fin_op;
    resp_in[manycore_link_pkg::RET_DATA_LSB +: manycore_link_pkg::DATA_W] =
      (fin_op == manycore_link_pkg::OP_STORE) ? fin_wdata : mem_q[fin_addr];
  end

  manycore_link_fifo #(.payload_t(manycore_link_pkg::ret_pkt_t)) resp_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .v_i      (consume),
    .data_i   (resp_in),
    .ready_o  (resp_ready),
    .v_o      (resp_v),
    .data_o   (resp_data),
    .yumi_i   (resp_yumi)
  );

  manycore_link_fifo #(.payload_t(manycore_link_pkg::ret_pkt_t)) east_ret_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .v_i      (ret_v_i),
    .data_i   (ret_data_i),
    .ready_o  (ret_ready_o),
    .v_o      (east_v),
    .data_o   (east_data),
    .yumi_i   (east_yumi)
  );

  // fixed priority, local first
  assign ret_v_o    = resp_v | east_v;
  assign ret_data_o = resp_v ? resp_data : east_data;
  assign resp_yumi  = resp_v & ret_ready_i;
  assign east_yumi  = east_v & ~resp_v & ret_ready_i;

endmodule

/* manycore_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the link subsystem: host controller and response timer at the
// west end, two memory tiles in a row, east tie-off at the far end.
// The host drives the Wishbone classic slave port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module manycore_top (
  input  logic                                   clk,
  input  logic                                   arst_n_i,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [manycore_host_pkg::WB_ADDR_W-1:0] wb_adr_i,
  input  logic [manycore_link_pkg::DATA_W-1:0]    wb_dat_i,
  output logic [manycore_link_pkg::DATA_W-1:0]    wb_dat_o,
  output logic                                   wb_ack_o,
  output logic                                   wb_err_o,
  output logic                                   misroute_o
);

  // forward link hops: 0 ctrl->tile0, 1 tile0->tile1, 2 tile1->tieoff
  logic                        fwd_v     [3];
  manycore_link_pkg::fwd_pkt_t fwd_data  [3];
  logic                        fwd_ready [3];

  // return link hops: 0 tile0->ctrl, 1 tile1->tile0
  logic                        ret_v     [2];
  manycore_link_pkg::ret_pkt_t ret_data  [2];
  logic                        ret_ready [2];

  logic timer_start;
  logic timer_stop;
  logic timer_expired;

  manycore_io_ctrl io_ctrl (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .fwd_v_o         (fwd_v[0]),
    .fwd_data_o      (fwd_data[0]),
    .fwd_ready_i     (fwd_ready[0]),
    .ret_v_i         (ret_v[0]),
    .ret_data_i      (ret_data[0]),
    .ret_ready_o     (ret_ready[0]),
    .timer_start_o   (timer_start),
    .timer_stop_o    (timer_stop),
    .timer_expired_i (timer_expired)
  );

  manycore_resp_timer resp_timer (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .start_i   (timer_start),
    .stop_i    (timer_stop),
    .expired_o (timer_expired)
  );

  manycore_tile #(.my_x_p(manycore_link_pkg::X_CORD_W'(0))) tile0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .fwd_v_i     (fwd_v[0]),
    .fwd_data_i  (fwd_data[0]),
    .fwd_ready_o (fwd_ready[0]),
    .fwd_v_o     (fwd_v[1]),
    .fwd_data_o  (fwd_data[1]),
    .fwd_ready_i (fwd_ready[1]),
    .ret_v_i     (ret_v[1]),
    .ret_data_i  (ret_data[1]),
    .ret_ready_o (ret_ready[1]),
    .ret_v_o     (ret_v[0]),
    .ret_data_o  (ret_data[0]),
    .ret_ready_i (ret_ready[0])
  );

  // last tile of the row, nothing returns from its east side
  manycore_tile #(
    .my_x_p(manycore_link_pkg::X_CORD_W'(manycore_link_pkg::NUM_TILES - 1))
  ) tile1 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .fwd_v_i     (fwd_v[1]),
    .fwd_data_i  (fwd_data[1]),
    .fwd_ready_o (fwd_ready[1]),
    .fwd_v_o     (fwd_v[2]),
    .fwd_data_o  (fwd_data[2]),
    .fwd_ready_i (fwd_ready[2]),
    .ret_v_i     (1'b0),
    .ret_data_i  ('0),
    .ret_ready_o (),
    .ret_v_o     (ret_v[1]),
    .ret_data_o  (ret_data[1]),
    .ret_ready_i (ret_ready[1])
  );

  manycore_link_tieoff tieoff_e (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .fwd_v_i     (fwd_v[2]),
    .fwd_data_i  (fwd_data[2]),
    .fwd_ready_o (fwd_ready[2]),
    .misroute_o  (misroute_o)
  );

endmodule

/* tb_manycore.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the manycore link subsystem. Runs Wishbone classic
// reads and writes against both tiles and the east edge, and compares the
// results with a word model of the two tile memories.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_manycore;

  localparam int CLK_PERIOD   = 20;
  localparam int DW           = manycore_link_pkg::DATA_W;
  localparam int WORDS        = 2**manycore_link_pkg::WORD_ADDR_W;
  localparam int RESP_LIMIT   = manycore_host_pkg::RESP_TIMEOUT + 10;
  localparam int NUM_ACCESSES = 2 + 2 + 64 + 3 + 16;  // tests in run order
  localparam int WATCHDOG_NS  = (NUM_ACCESSES * RESP_LIMIT + 200) * CLK_PERIOD;

  logic                                   clk;
  logic                                   arst_n_i;
  logic                                   wb_cyc_i;
  logic                                   wb_stb_i;
  logic                                   wb_we_i;
  logic [manycore_host_pkg::WB_ADDR_W-1:0] wb_adr_i;
  logic [DW-1:0]                          wb_dat_i;
  logic [DW-1:0]                          wb_dat_o;
  logic                                   wb_ack_o;
  logic                                   wb_err_o;
  logic                                   misroute_o;

  logic [DW-1:0] model [manycore_link_pkg::NUM_TILES][WORDS];  // mirrors every store
  integer        seed;
  int            errors;
  int            accesses;

  manycore_top UUT (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .misroute_o (misroute_o)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic check_bit(input string name, input logic value, input logic expected);
    if (value !== expected) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, value, expected);
      errors = errors + 1;
    end
  endtask

  // one access, bus left asserted so the next one can follow at once
  task automatic bus_cycle(input logic we, input int x, input int w, input logic [DW-1:0] wdata,
                           output logic [DW-1:0] rdata, output logic ack, output logic err);
    int n;
    @(posedge clk);
    #2;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {manycore_host_pkg::WB_X_W'(x), manycore_host_pkg::WB_WORD_W'(w)};
    wb_dat_i = wdata;
    ack   = 1'b0;
    err   = 1'b0;
    rdata = '0;
    n     = 0;
    while (!ack && !err && n < RESP_LIMIT) begin
      @(posedge clk);
      #1;  // outputs settled after the edge
      ack   = wb_ack_o;
      err   = wb_err_o;
      rdata = wb_dat_o;
      n     = n + 1;
    end
    accesses = accesses + 1;
    if (!ack && !err) begin
      $display("no ack or err from the DUT within %0d cycles, x %0d word %0d", RESP_LIMIT, x, w);
      errors = errors + 1;
    end
  endtask

  task automatic bus_release();
    @(posedge clk);
    #2;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input int x, input int w, input logic [DW-1:0] data);
    logic [DW-1:0] rdata;
    logic          ack;
    logic          err;
    bus_cycle(1'b1, x, w, data, rdata, ack, err);
    model[x][w] = data;
    if (err) begin
      $display("write to tile %0d word %0d ended with err instead of ack", x, w);
      errors = errors + 1;
    end
  endtask

  task automatic wb_read(input int x, input int w);
    logic [DW-1:0] rdata;
    logic          ack;
    logic          err;
    bus_cycle(1'b0, x, w, '0, rdata, ack, err);
    if (err) begin
      $display("read of tile %0d word %0d ended with err instead of ack", x, w);
      errors = errors + 1;
    end else if (ack && rdata !== model[x][w]) begin
      $display("Fail at %0t: tile %0d word %0d read %h, expected %h",
               $time, x, w, rdata, model[x][w]);
      errors = errors + 1;
    end
  endtask

  // no tile at x, so the tie-off eats it and the timer ends the cycle
  task automatic misroute_access(input logic we, input int x, input int w);
    logic [DW-1:0] data;
    logic          ack;
    logic          err;
    data = $random(seed);
    bus_cycle(we, x, w, data, data, ack, err);
    if (ack) begin
      $display("access to x %0d was acknowledged although no tile sits there", x);
      errors = errors + 1;
    end
    check_bit("misroute_o", misroute_o, 1'b1);
  endtask

  task automatic test_reset_state();
    check_bit("wb_ack_o after reset", wb_ack_o, 1'b0);
    check_bit("wb_err_o after reset", wb_err_o, 1'b0);
    check_bit("misroute_o after reset", misroute_o, 1'b0);
  endtask

  task automatic test_tile_rw(input int x);
    logic [DW-1:0] data;
    data = $random(seed);
    wb_write(x, 5, data);
    bus_release();
    wb_read(x, 5);
    bus_release();
  endtask

  task automatic test_all_words();
    logic [DW-1:0] data;
    for (int x = 0; x < manycore_link_pkg::NUM_TILES; x++) begin
      for (int w = 0; w < WORDS; w++) begin
        data = $random(seed);
        wb_write(x, w, data);
        bus_release();
      end
    end
    for (int x = 0; x < manycore_link_pkg::NUM_TILES; x++) begin
      for (int w = 0; w < WORDS; w++) begin
        wb_read(x, w);
        bus_release();
      end
    end
  endtask

  task automatic test_misroute();
    // valid traffic so far must not have raised the flag
    check_bit("misroute_o before stray access", misroute_o, 1'b0);
    misroute_access(1'b0, 2, 3);
    bus_release();
    misroute_access(1'b1, 3, 9);
    bus_release();
    wb_read(0, 7);  // tile 0 unharmed
    bus_release();
    check_bit("misroute_o after tile 0 read", misroute_o, 1'b1);
  endtask

  task automatic test_back_to_back();
    logic [DW-1:0] data;
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      wb_write(i % 2, i, data);
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(i % 2, i);
    end
    bus_release();
  endtask

  initial begin
    seed     = 97;
    errors   = 0;
    accesses = 0;
    clk      = 1'b0;
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (8) @(posedge clk);
    #2;
    arst_n_i = 1'b1;
    @(posedge clk);
    #1;
    test_reset_state();
    test_tile_rw(0);
    test_tile_rw(1);  // through tile 0 and back
    test_all_words();
    test_misroute();
    test_back_to_back();
    $display("accesses: %0d, errors: %0d", accesses, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("Test FAILED");
    $finish;
  end

endmodule
